// ==== concat_unit.f ====
common/cat_pkg.sv
common/glb_rd_if.sv
common/cat_tag_if.sv
cat/cat_addr_gen.sv
cat/cat_tag_fifo.sv
cat/cat_writer.sv
source/glb_bank.sv
source/concat_unit.sv
dv/tb_clk_gen.sv
dv/concat_unit_assert.sv
dv/concat_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the concatenation unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=concat_unit_sim
LOG=sim.log

verilator --binary --timing --assert \
    --top-module concat_unit_tb \
    -f concat_unit.f \
    -Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the summary is printed
"./$OBJ_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail, see $LOG"
    exit 1
fi

// ==== dv/concat_unit_tb.sv ====
// ==================================================
// Testbench for the concatenation unit
//   LFSR stimulus, bank preload and mirrors
//   Reference model, write comparator, watchdog
// ==================================================
`timescale 1ns/1ps

module concat_unit_tb;

    localparam int AW    = cat_pkg::ADDR_WIDTH_DEF;
    localparam int DW    = cat_pkg::SRAM_WIDTH_DEF;
    localparam int BAW   = cat_pkg::BANK_AW_DEF;
    localparam int CW    = cat_pkg::CFG_WIDTH;
    localparam int DEPTH = 2 ** BAW;
    // Words over all jobs below
    localparam int TOTAL_WORDS    = 20 + 15 + 12 + 30 + 16 + 12;
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 2000;

    logic          clk;
    logic          rst_n;
    logic          cfg_vld;
    logic          cfg_rdy;
    logic [CW-1:0] cfg_info;
    logic          load_en;
    logic          load_sel;
    logic [BAW-1:0] load_addr;
    logic [DW-1:0] load_dat;
    logic [AW-1:0] wr_addr;
    logic [DW-1:0] wr_dat;
    logic          wr_vld;
    logic          wr_rdy = 1'b1;

    // Bank mirrors and current job fields
    logic [DW-1:0] mem0 [DEPTH];
    logic [DW-1:0] mem1 [DEPTH];
    logic [AW-1:0] j_np;
    logic [AW-1:0] j_w0;
    logic [AW-1:0] j_w1;
    logic [AW-1:0] j_cat;
    logic [AW-1:0] j_e0;
    logic [AW-1:0] j_e1;

    // Expected writes, oldest first
    logic [AW-1:0] exp_addr_q [$];
    logic [DW-1:0] exp_dat_q  [$];

    logic [31:0] lfsr_state = 32'hd7657df5;
    logic        rdy_random = 1'b0;
    string       cur_test   = "reset_state";
    int          errors     = 0;
    int          checks     = 0;
    int          tests      = 0;
    int          test_start = 0;

    tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(8)) clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    concat_unit concat_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_vld   (cfg_vld),
        .cfg_rdy   (cfg_rdy),
        .cfg_info  (cfg_info),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_dat  (load_dat),
        .wr_addr   (wr_addr),
        .wr_dat    (wr_dat),
        .wr_vld    (wr_vld),
        .wr_rdy    (wr_rdy)
    );

    bind concat_unit concat_unit_assert #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SRAM_WIDTH (SRAM_WIDTH)
    ) assert_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_vld  (wr_vld),
        .wr_rdy  (wr_rdy),
        .wr_addr (wr_addr),
        .wr_dat  (wr_dat)
    );

    // ==================================================
    // Random source
    // ==================================================
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic logic [DW-1:0] rand_word();
        logic [DW-1:0] v;
        for (int i = 0; i < DW; i++) begin
            v[i] = rand_bit();
        end
        return v;
    endfunction

    // ==================================================
    // Reference model
    // ==================================================
    // Word k of the job: point k / wpp, word k % wpp
    function automatic void ref_cat(input int k, output logic [AW-1:0] addr,
                                    output logic [DW-1:0] dat);
        int wpp;
        int p;
        int w;
        int row;
        wpp  = int'(j_w0) + int'(j_w1);
        p    = k / wpp;
        w    = k % wpp;
        addr = AW'(int'(j_cat) + k);
        if (w < int'(j_w0)) begin
            row = int'(j_e0) + int'(j_w0) * p + w;
            dat = mem0[BAW'(row)];
        end else begin
            row = int'(j_e1) + int'(j_w1) * p + (w - int'(j_w0));
            dat = mem1[BAW'(row)];
        end
    endfunction

    function automatic logic [CW-1:0] make_cfg();
        logic [CW-1:0] c;
        c = '0;
        c[cat_pkg::CFG_NUM_PNT_LSB +: AW] = j_np;
        c[cat_pkg::CFG_WORD0_LSB +: AW]   = j_w0;
        c[cat_pkg::CFG_WORD1_LSB +: AW]   = j_w1;
        c[cat_pkg::CFG_CAT_LSB +: AW]     = j_cat;
        c[cat_pkg::CFG_ELE1_LSB +: AW]    = j_e1;
        c[cat_pkg::CFG_ELE0_LSB +: AW]    = j_e0;
        return c;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_addr(input string name, input logic [AW-1:0] exp_v,
                              input logic [AW-1:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("Mismatch %s wr_addr: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_dat(input string name, input logic [DW-1:0] exp_v,
                             input logic [DW-1:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("Mismatch %s wr_dat: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("Mismatch %s flag: expected %b, actual %b", name, exp_v, act_v);
        end
    endtask

    // Write comparator, negedge sees a settled handshake
    always @(negedge clk) begin : compare_writes
        logic [AW-1:0] ea;
        logic [DW-1:0] ed;
        if (rst_n && wr_vld && wr_rdy) begin
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("Unexpected write to %h in test %s", wr_addr, cur_test);
            end else begin
                ea = exp_addr_q.pop_front();
                ed = exp_dat_q.pop_front();
                check_addr(cur_test, ea, wr_addr);
                check_dat(cur_test, ed, wr_dat);
            end
        end
    end

    // Result port back-pressure
    always @(posedge clk) begin
        #2;
        wr_rdy = rdy_random ? rand_bit() : 1'b1;
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic preload_banks();
        logic [DW-1:0] d;
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < DEPTH; a++) begin
                d = rand_word();
                if (b == 0) begin
                    mem0[BAW'(a)] = d;
                end else begin
                    mem1[BAW'(a)] = d;
                end
                @(posedge clk);
                #2;
                load_en   = 1'b1;
                load_sel  = (b == 1);
                load_addr = BAW'(a);
                load_dat  = d;
            end
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
    endtask

    task automatic run_job(input int np, input int w0, input int w1,
                           input int cat, input int e0, input int e1);
        logic [AW-1:0] ea;
        logic [DW-1:0] ed;
        j_np  = AW'(np);
        j_w0  = AW'(w0);
        j_w1  = AW'(w1);
        j_cat = AW'(cat);
        j_e0  = AW'(e0);
        j_e1  = AW'(e1);
        for (int k = 0; k < (w0 + w1) * np; k++) begin
            ref_cat(k, ea, ed);
            exp_addr_q.push_back(ea);
            exp_dat_q.push_back(ed);
        end
        @(posedge clk);
        #2;
        cfg_info = make_cfg();
        cfg_vld  = 1'b1;
        // Handshake on the edge after cfg_rdy is seen
        do begin
            @(negedge clk);
        end while (!cfg_rdy);
        @(posedge clk);
        #2;
        cfg_vld = 1'b0;
        // Engine idle again marks the job end
        do begin
            @(negedge clk);
        end while (!cfg_rdy);
        if (exp_addr_q.size() != 0) begin
            errors++;
            $display("Test %s ended with %0d results never written", cur_test,
                     exp_addr_q.size());
            exp_addr_q.delete();
            exp_dat_q.delete();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        test_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s: %s, %0d errors", cur_test,
                 (errors == test_start) ? "ok" : "failed", errors - test_start);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        cfg_vld   = 1'b0;
        cfg_info  = '0;
        load_en   = 1'b0;
        load_sel  = 1'b0;
        load_addr = '0;
        load_dat  = '0;
        @(posedge rst_n);
        @(negedge clk);

        begin_test("reset_state");
        check_flag(cur_test, 1'b1, cfg_rdy);
        check_flag(cur_test, 1'b0, wr_vld);
        end_test();

        preload_banks();

        begin_test("basic");
        run_job(4, 2, 3, 'h0100, 8, 32);
        end_test();

        begin_test("ele1_only");
        run_job(5, 0, 3, 'h0200, 0, 100);
        end_test();

        begin_test("ele0_only");
        run_job(3, 4, 0, 'h0300, 60, 0);
        end_test();

        // Result port stalls at random
        begin_test("backpressure");
        @(negedge clk);
        rdy_random = 1'b1;
        run_job(6, 3, 2, 'h0400, 120, 150);
        @(negedge clk);
        rdy_random = 1'b0;
        end_test();

        // Second job sent as soon as the first ends
        begin_test("back_to_back");
        run_job(8, 1, 1, 'h0500, 200, 10);
        run_job(3, 2, 2, 'h0600, 30, 220);
        end_test();

        errors += int'(concat_unit_inst.assert_inst.fail_cnt);
        $display("Summary: %0d tests, %0d checks, %0d errors (%0d from assertions)",
                 tests, checks, errors, concat_unit_inst.assert_inst.fail_cnt);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles, stuck in test %s",
                 TIMEOUT_CYCLES, cur_test);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== dv/concat_unit_assert.sv ====
// ==================================================
// Bound checks on the top-level handshakes
//   Result payload held under back-pressure
//   Idle result port out of reset
// ==================================================
`timescale 1ns/1ps

module concat_unit_assert #(
    parameter int ADDR_WIDTH = 16,
    parameter int SRAM_WIDTH = 256
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  wr_vld,
    input logic                  wr_rdy,
    input logic [ADDR_WIDTH-1:0] wr_addr,
    input logic [SRAM_WIDTH-1:0] wr_dat
);

    // Read by the testbench summary
    int unsigned fail_cnt = 0;

    // Stalled write keeps valid and payload
    wr_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && !wr_rdy |=> wr_vld && $stable(wr_addr) && $stable(wr_dat))
    else begin
        $error("wr_addr or wr_dat changed while the write was stalled");
        fail_cnt++;
    end

    // No write pending during or right after reset
    wr_idle_a : assert property (@(posedge clk) !rst_n || $rose(rst_n) |-> !wr_vld)
    else begin
        $error("wr_vld high out of reset");
        fail_cnt++;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
// ==================================================
// Testbench clock and reset
//   Free-running clock, active-low reset
// ==================================================
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release just after an edge, like the other drivers
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== source/concat_unit.sv ====
// ==================================================
// Concatenation unit top level
//   Address producer, tag FIFO, result writer
//   Two element banks with steered preload
// ==================================================
`timescale 1ns/1ps

module concat_unit #(
    parameter int SRAM_WIDTH = cat_pkg::SRAM_WIDTH_DEF,
    parameter int ADDR_WIDTH = cat_pkg::ADDR_WIDTH_DEF,
    parameter int BANK_AW    = cat_pkg::BANK_AW_DEF,
    parameter int TAG_DEPTH  = cat_pkg::TAG_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Configuration from the controller
    input  logic                          cfg_vld,
    output logic                          cfg_rdy,
    input  logic [cat_pkg::CFG_WIDTH-1:0] cfg_info,
    // Bank preload
    input  logic                          load_en,
    input  logic                          load_sel,
    input  logic [BANK_AW-1:0]            load_addr,
    input  logic [SRAM_WIDTH-1:0]         load_dat,
    // Result write port
    output logic [ADDR_WIDTH-1:0]         wr_addr,
    output logic [SRAM_WIDTH-1:0]         wr_dat,
    output logic                          wr_vld,
    input  logic                          wr_rdy
);

    logic                  job_done;
    logic [ADDR_WIDTH-1:0] cat_base;

    glb_rd_if #(.ADDR_WIDTH(ADDR_WIDTH), .SRAM_WIDTH(SRAM_WIDTH)) rd0 ();
    glb_rd_if #(.ADDR_WIDTH(ADDR_WIDTH), .SRAM_WIDTH(SRAM_WIDTH)) rd1 ();
    cat_tag_if #(.ADDR_WIDTH(ADDR_WIDTH)) tag_in ();
    cat_tag_if #(.ADDR_WIDTH(ADDR_WIDTH)) tag_out ();

    // ==================================================
    // Engine
    // ==================================================
    cat_addr_gen #(.ADDR_WIDTH(ADDR_WIDTH)) addr_gen_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_vld  (cfg_vld),
        .cfg_info (cfg_info),
        .cfg_rdy  (cfg_rdy),
        .job_done (job_done),
        .rd0      (rd0),
        .rd1      (rd1),
        .tag      (tag_in),
        .cat_base (cat_base)
    );

    cat_tag_fifo #(.ADDR_WIDTH(ADDR_WIDTH), .TAG_DEPTH(TAG_DEPTH)) tag_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (tag_in),
        .out   (tag_out)
    );

    cat_writer #(.ADDR_WIDTH(ADDR_WIDTH), .SRAM_WIDTH(SRAM_WIDTH)) writer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tag      (tag_out),
        .rd0      (rd0),
        .rd1      (rd1),
        .cat_base (cat_base),
        .wr_addr  (wr_addr),
        .wr_dat   (wr_dat),
        .wr_vld   (wr_vld),
        .wr_rdy   (wr_rdy),
        .job_done (job_done)
    );

    // ==================================================
    // Element banks, load_sel picks bank 1
    // ==================================================
    glb_bank #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SRAM_WIDTH (SRAM_WIDTH),
        .BANK_AW    (BANK_AW)
    ) bank0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en && !load_sel),
        .load_addr (load_addr),
        .load_dat  (load_dat),
        .rd        (rd0)
    );

    glb_bank #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SRAM_WIDTH (SRAM_WIDTH),
        .BANK_AW    (BANK_AW)
    ) bank1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en && load_sel),
        .load_addr (load_addr),
        .load_dat  (load_dat),
        .rd        (rd1)
    );

endmodule

// ==== source/glb_bank.sv ====
// ==================================================
// Global-buffer bank
//   SRAM array with a preload write port
//   One-cycle read with held data register
// ==================================================
`timescale 1ns/1ps

module glb_bank #(
    parameter int ADDR_WIDTH = 16,
    parameter int SRAM_WIDTH = 256,
    parameter int BANK_AW    = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_en,
    input  logic [BANK_AW-1:0]    load_addr,
    input  logic [SRAM_WIDTH-1:0] load_dat,
    glb_rd_if.bank                rd
);

    localparam int DEPTH = 2 ** BANK_AW;

    logic [SRAM_WIDTH-1:0] mem [DEPTH];
    logic [BANK_AW-1:0]    rd_row;
    logic                  rd_fire;

    // Only the low bits address the array
    assign rd_row  = rd.addr[BANK_AW-1:0];
    // Accept a new read while the data register frees up
    assign rd.addr_rdy = !rd.dat_vld || rd.dat_rdy;
    assign rd_fire     = rd.addr_vld && rd.addr_rdy;

    // ==================================================
    // Array
    // ==================================================
    // Preload port, one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_dat;
        end
    end

    // Read data register, held until taken
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd.dat <= mem[rd_row];
        end
    end

    // ==================================================
    // Read valid
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd.dat_vld <= 1'b0;
        end else if (rd.addr_rdy) begin
            rd.dat_vld <= rd_fire;
        end
    end

endmodule

// ==== cat/cat_writer.sv ====
// ==================================================
// Result writer
//   Accepts bank data in tag order
//   Output register with result address
//   End-of-job pulse on the final write
// ==================================================
`timescale 1ns/1ps

module cat_writer #(
    parameter int ADDR_WIDTH = 16,
    parameter int SRAM_WIDTH = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    cat_tag_if.dst                tag,
    glb_rd_if.engine              rd0,
    glb_rd_if.engine              rd1,
    input  logic [ADDR_WIDTH-1:0] cat_base,
    output logic [ADDR_WIDTH-1:0] wr_addr,
    output logic [SRAM_WIDTH-1:0] wr_dat,
    output logic                  wr_vld,
    input  logic                  wr_rdy,
    output logic                  job_done
);

    logic out_free;
    logic dat_vld;
    logic accept;
    // Last flag of the word held in the output register
    logic last_q;

    // ==================================================
    // Data acceptance
    // ==================================================
    // Register empty or draining this cycle
    assign out_free = !wr_vld || wr_rdy;
    // Head tag points at the bank that owns the oldest word
    assign dat_vld  = tag.sel ? rd0.dat_vld : rd1.dat_vld;
    assign accept   = tag.vld && dat_vld && out_free;

    // Pop the tag as the data is taken
    assign tag.rdy     = dat_vld && out_free;
    assign rd0.dat_rdy = tag.vld && tag.sel && out_free;
    assign rd1.dat_rdy = tag.vld && !tag.sel && out_free;

    // Output payload
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_dat  <= tag.sel ? rd0.dat : rd1.dat;
            wr_addr <= cat_base + tag.idx;
            last_q  <= tag.last;
        end
    end

    // Output valid, held under back-pressure
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_vld <= 1'b0;
        end else if (out_free) begin
            wr_vld <= accept;
        end
    end

    // Job ends when the last word leaves
    assign job_done = wr_vld && wr_rdy && last_q;

endmodule

// ==== cat/cat_tag_fifo.sv ====
// ==================================================
// In-flight tag FIFO
//   Circular buffer, all TAG_DEPTH entries usable
//   Push and pop allowed in one cycle
// ==================================================
`timescale 1ns/1ps

module cat_tag_fifo #(
    parameter int ADDR_WIDTH = 16,
    parameter int TAG_DEPTH  = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    cat_tag_if.dst in,
    cat_tag_if.src out
);

    localparam int PW = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
    localparam int CW = $clog2(TAG_DEPTH + 1);
    // Entry is {sel, last, idx}
    localparam int EW = ADDR_WIDTH + 2;

    logic [EW-1:0] mem [TAG_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    // Ready and valid come straight from occupancy
    assign in.rdy  = (count != CW'(TAG_DEPTH));
    assign out.vld = (count != '0);
    assign push    = in.vld && in.rdy;
    assign pop     = out.vld && out.rdy;

    assign {out.sel, out.last, out.idx} = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in.sel, in.last, in.idx};
        end
    end

    // ==================================================
    // Pointers and occupancy
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // Explicit wrap, depth need not be a power of two
                wr_ptr <= (wr_ptr == PW'(TAG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(TAG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== cat/cat_addr_gen.sv ====
// ==================================================
// Address producer
//   Job FSM, idle / issue / drain
//   Point and word counters with running bank bases
//   Read address issue to both banks plus tag push
// ==================================================
`timescale 1ns/1ps

module cat_addr_gen #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_vld,
    input  logic [cat_pkg::CFG_WIDTH-1:0] cfg_info,
    output logic                          cfg_rdy,
    input  logic                          job_done,
    glb_rd_if.engine                      rd0,
    glb_rd_if.engine                      rd1,
    cat_tag_if.src                        tag,
    output logic [ADDR_WIDTH-1:0]         cat_base
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    logic [1:0]            state;
    logic [ADDR_WIDTH-1:0] num_pnt;
    logic [ADDR_WIDTH-1:0] word0;
    logic [ADDR_WIDTH-1:0] word1;
    logic [ADDR_WIDTH-1:0] wpp;
    // p: point, w: word in point, k: running index
    logic [ADDR_WIDTH-1:0] p;
    logic [ADDR_WIDTH-1:0] w;
    logic [ADDR_WIDTH-1:0] k;
    // ele0 + word0*p and ele1 + word1*p, kept as sums
    logic [ADDR_WIDTH-1:0] base0;
    logic [ADDR_WIDTH-1:0] base1;
    logic                  sel_e0;
    logic                  pnt_end;
    logic                  last;
    logic                  cfg_fire;
    logic                  fire;

    // ==================================================
    // Configuration capture
    // ==================================================
    assign cfg_rdy  = (state == ST_IDLE);
    assign cfg_fire = cfg_vld && cfg_rdy;

    always_ff @(posedge clk) begin
        if (cfg_fire) begin
            num_pnt  <= cfg_info[cat_pkg::CFG_NUM_PNT_LSB +: ADDR_WIDTH];
            word0    <= cfg_info[cat_pkg::CFG_WORD0_LSB +: ADDR_WIDTH];
            word1    <= cfg_info[cat_pkg::CFG_WORD1_LSB +: ADDR_WIDTH];
            cat_base <= cfg_info[cat_pkg::CFG_CAT_LSB +: ADDR_WIDTH];
        end
    end

    // Words fetched per point, both elements
    assign wpp = word0 + word1;

    // ==================================================
    // Issue decision
    // ==================================================
    // Leading word0 words of a point belong to element 0
    assign sel_e0  = (w < word0);
    assign pnt_end = (w == wpp - 1'b1);
    assign last    = pnt_end && (p == num_pnt - 1'b1);

    // FIFO ready can only fall on a push, so valid stays stable
    assign rd0.addr_vld = (state == ST_ISSUE) && sel_e0 && tag.rdy;
    assign rd1.addr_vld = (state == ST_ISSUE) && !sel_e0 && tag.rdy;
    assign rd0.addr     = base0 + w;
    assign rd1.addr     = base1 + (w - word0);

    // One request per accepted address
    assign fire = (rd0.addr_vld && rd0.addr_rdy) || (rd1.addr_vld && rd1.addr_rdy);

    // Tag enters the FIFO together with the address
    assign tag.vld  = fire;
    assign tag.sel  = sel_e0;
    assign tag.last = last;
    assign tag.idx  = k;

    // ==================================================
    // FSM and counters
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            p     <= '0;
            w     <= '0;
            k     <= '0;
            base0 <= '0;
            base1 <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cfg_fire) begin
                        state <= ST_ISSUE;
                        p     <= '0;
                        w     <= '0;
                        k     <= '0;
                        base0 <= cfg_info[cat_pkg::CFG_ELE0_LSB +: ADDR_WIDTH];
                        base1 <= cfg_info[cat_pkg::CFG_ELE1_LSB +: ADDR_WIDTH];
                    end
                end
                ST_ISSUE: begin
                    if (fire) begin
                        k <= k + 1'b1;
                        if (last) begin
                            state <= ST_DRAIN;
                        end else if (pnt_end) begin
                            // Step both bases to the next point
                            w     <= '0;
                            p     <= p + 1'b1;
                            base0 <= base0 + word0;
                            base1 <= base1 + word1;
                        end else begin
                            w <= w + 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // Wait for the writer to hand off the last word
                    if (job_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== common/cat_tag_if.sv ====
// ==================================================
// Request tag channel
//   Bank select, last flag and word index per read
// ==================================================
`timescale 1ns/1ps

interface cat_tag_if #(
    parameter int ADDR_WIDTH = cat_pkg::ADDR_WIDTH_DEF
);

    logic                  vld;
    logic                  rdy;
    // 1 means the word comes from element 0
    logic                  sel;
    // Final word of the job
    logic                  last;
    // Running word index, offset from the result base
    logic [ADDR_WIDTH-1:0] idx;

    modport src (output vld, sel, last, idx, input rdy);
    modport dst (input vld, sel, last, idx, output rdy);

endinterface

// ==== common/glb_rd_if.sv ====
// ==================================================
// Read port between the engine and one bank
//   Address channel and data channel, each valid/ready
// ==================================================
`timescale 1ns/1ps

interface glb_rd_if #(
    parameter int ADDR_WIDTH = cat_pkg::ADDR_WIDTH_DEF,
    parameter int SRAM_WIDTH = cat_pkg::SRAM_WIDTH_DEF
);

    // Address channel, engine to bank
    logic [ADDR_WIDTH-1:0] addr;
    logic                  addr_vld;
    logic                  addr_rdy;

    // Data channel, bank to engine
    logic [SRAM_WIDTH-1:0] dat;
    logic                  dat_vld;
    logic                  dat_rdy;

    // Producer drives addresses, writer drives dat_rdy
    modport engine (
        output addr, addr_vld, dat_rdy,
        input  addr_rdy, dat, dat_vld
    );

    modport bank (
        input  addr, addr_vld, dat_rdy,
        output addr_rdy, dat, dat_vld
    );

endinterface

// ==== common/cat_pkg.sv ====
// ==================================================
// Shared constants for the concatenation engine
//   Default widths and depths for the parameters
//   Configuration word width and field offsets
// ==================================================
package cat_pkg;

    // ==================================================
    // Default parameter values
    // ==================================================
    // Data word of one global-buffer entry
    localparam int SRAM_WIDTH_DEF = 256;
    // Result, element and count fields
    localparam int ADDR_WIDTH_DEF = 16;
    // Address bits decoded by one bank
    localparam int BANK_AW_DEF    = 8;
    // Requests allowed in flight
    localparam int TAG_DEPTH_DEF  = 4;

    // ==================================================
    // Configuration word layout
    // ==================================================
    localparam int CFG_WIDTH = 128;

    // Bits 15:0 are reserved for the controller opcode
    // Fields are ADDR_WIDTH wide, packed upward from bit 16
    // Number of points in the job
    localparam int CFG_NUM_PNT_LSB = 16;
    // Words per point taken from element 0
    localparam int CFG_WORD0_LSB   = CFG_NUM_PNT_LSB + ADDR_WIDTH_DEF;
    // Words per point taken from element 1
    localparam int CFG_WORD1_LSB   = CFG_WORD0_LSB + ADDR_WIDTH_DEF;
    // Base of the result area
    localparam int CFG_CAT_LSB     = CFG_WORD1_LSB + ADDR_WIDTH_DEF;
    // Base of element 1 in bank 1
    localparam int CFG_ELE1_LSB    = CFG_CAT_LSB + ADDR_WIDTH_DEF;
    // Base of element 0 in bank 0
    localparam int CFG_ELE0_LSB    = CFG_ELE1_LSB + ADDR_WIDTH_DEF;

endpackage
